// ==== hw/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data path width
`define RV_XLEN 32

// architectural registers including x0
`define RV_REG_COUNT 32

`define RV_REG_IDX_W 5

// first fetch address
`define RV_RESET_PC 32'h0000_0000

// bytes per instruction
`define RV_PC_STEP 32'd4

`endif

// ==== hw/rv_pkg.sv ====
`default_nettype none

`include "rv_defs.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;

    // byte address as wide as a word
    typedef logic [`RV_XLEN-1:0] addr_t;

    typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;

    // alu operations kept in this core
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT
    } alu_op_e;

    // immediate layouts
    typedef enum logic [1:0] {
        IMM_I,
        IMM_SHAMT,
        IMM_U
    } imm_fmt_e;

endpackage

`default_nettype wire

// ==== hw/rv_decoder.sv ====
`default_nettype none

module rv_decoder (
    input  rv_pkg::word_t    instr,
    output rv_pkg::reg_idx_t rs1,
    output rv_pkg::reg_idx_t rs2,
    output rv_pkg::reg_idx_t rd,
    output rv_pkg::alu_op_e  alu_op,
    output logic             use_imm,
    output logic             is_load,
    output logic             is_lui,
    output logic             reg_write,
    output rv_pkg::word_t    imm
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;

    logic [2:0]       funct3;
    logic [6:0]       funct7;
    rv_pkg::imm_fmt_e imm_fmt;

    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        alu_op    = rv_pkg::ADD;
        use_imm   = 1'b0;
        is_load   = 1'b0;
        is_lui    = 1'b0;
        reg_write = 1'b0;
        imm_fmt   = rv_pkg::IMM_I;
        case (instr[6:0])
            OPC_OP: begin
                reg_write = 1'b1;
                case (funct3)
                    3'b000:  alu_op = funct7[5] ? rv_pkg::SUB : rv_pkg::ADD;
                    3'b001:  alu_op = rv_pkg::SLL;
                    3'b010:  alu_op = rv_pkg::SLT;
                    3'b100:  alu_op = rv_pkg::XOR;
                    3'b101:  alu_op = funct7[5] ? rv_pkg::SRA : rv_pkg::SRL;
                    3'b110:  alu_op = rv_pkg::OR;
                    3'b111:  alu_op = rv_pkg::AND;
                    // sltu is not kept
                    default: reg_write = 1'b0;
                endcase
                // only sub and sra may set funct7 bit 5
                if ({funct7[6], funct7[4:0]} != 6'b0 ||
                    (funct7[5] && funct3 != 3'b000 && funct3 != 3'b101)) begin
                    reg_write = 1'b0;
                end
            end
            OPC_OP_IMM: begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                case (funct3)
                    3'b000:  alu_op = rv_pkg::ADD;
                    3'b100:  alu_op = rv_pkg::XOR;
                    3'b110:  alu_op = rv_pkg::OR;
                    3'b111:  alu_op = rv_pkg::AND;
                    3'b001: begin
                        alu_op    = rv_pkg::SLL;
                        imm_fmt   = rv_pkg::IMM_SHAMT;
                        reg_write = (funct7 == 7'b0000000);
                    end
                    3'b101: begin
                        alu_op    = funct7[5] ? rv_pkg::SRA : rv_pkg::SRL;
                        imm_fmt   = rv_pkg::IMM_SHAMT;
                        reg_write = ({funct7[6], funct7[4:0]} == 6'b0);
                    end
                    // slti and sltiu retire as no-ops
                    default: reg_write = 1'b0;
                endcase
            end
            OPC_LOAD: begin
                is_load   = 1'b1;
                use_imm   = 1'b1;
                reg_write = (funct3 == 3'b010);
            end
            OPC_LUI: begin
                is_lui    = 1'b1;
                reg_write = 1'b1;
                imm_fmt   = rv_pkg::IMM_U;
            end
            default: reg_write = 1'b0;
        endcase
    end

    always_comb begin
        case (imm_fmt)
            rv_pkg::IMM_SHAMT: imm = {27'b0, instr[24:20]};
            rv_pkg::IMM_U:     imm = {instr[31:12], 12'b0};
            default:           imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/rv_regfile.sv ====
`default_nettype none

`include "rv_defs.svh"

module rv_regfile (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  rv_pkg::reg_idx_t rd,
    input  logic             wr_en,
    input  rv_pkg::word_t    wr_data,
    output rv_pkg::word_t    rd1,
    output rv_pkg::word_t    rd2
);

    // x0 has no storage
    rv_pkg::word_t regs [1:`RV_REG_COUNT-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && rd != '0) begin
            regs[rd] <= wr_data;
        end
    end

    // combinational reads
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== hw/rv_alu.sv ====
`default_nettype none

module rv_alu (
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  rv_pkg::alu_op_e op,
    output rv_pkg::word_t   result
);

    logic [4:0] shamt;

    // only the low five bits shift
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv_pkg::ADD: result = a + b;
            rv_pkg::SUB: result = a - b;
            rv_pkg::AND: result = a & b;
            rv_pkg::OR:  result = a | b;
            rv_pkg::XOR: result = a ^ b;
            rv_pkg::SLL: result = a << shamt;
            rv_pkg::SRL: result = a >> shamt;
            rv_pkg::SRA: result = rv_pkg::word_t'($signed(a) >>> shamt);
            // signed compare yields 1 or 0
            rv_pkg::SLT: result = rv_pkg::word_t'($signed(a) < $signed(b));
            default:     result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/rv_core.sv ====
`default_nettype none

`include "rv_defs.svh"

module rv_core (
    input  logic             clk,
    input  logic             rst_n,
    output rv_pkg::addr_t    imem_addr,
    input  rv_pkg::word_t    imem_data,
    input  logic             imem_valid,
    output rv_pkg::addr_t    dmem_addr,
    input  rv_pkg::word_t    dmem_rdata,
    output logic             wb_valid,
    output rv_pkg::reg_idx_t wb_rd,
    output rv_pkg::word_t    wb_data
);

    rv_pkg::addr_t    pc;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::reg_idx_t rd;
    rv_pkg::alu_op_e  alu_op;
    logic             use_imm;
    logic             is_load;
    logic             is_lui;
    logic             reg_write;
    rv_pkg::word_t    imm;
    rv_pkg::word_t    rd1;
    rv_pkg::word_t    rd2;
    rv_pkg::word_t    alu_b;
    rv_pkg::word_t    alu_result;
    rv_pkg::word_t    wr_data;
    logic             wr_en;

    // pc steps only on an accepted fetch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RV_RESET_PC;
        end else if (imem_valid) begin
            pc <= pc + `RV_PC_STEP;
        end
    end

    assign imem_addr = pc;

    rv_decoder u_decoder (
        .instr     (imem_data),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .alu_op    (alu_op),
        .use_imm   (use_imm),
        .is_load   (is_load),
        .is_lui    (is_lui),
        .reg_write (reg_write),
        .imm       (imm)
    );

    rv_regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rd1     (rd1),
        .rd2     (rd2)
    );

    assign alu_b = use_imm ? imm : rd2;

    rv_alu u_alu (
        .a      (rd1),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result)
    );

    // load address is rs1 plus offset
    assign dmem_addr = alu_result;

    always_comb begin
        if (is_lui) begin
            wr_data = imm;
        end else if (is_load) begin
            wr_data = dmem_rdata;
        end else begin
            wr_data = alu_result;
        end
    end

    // x0 writes never show on the trace
    assign wr_en = imem_valid && reg_write && (rd != '0);

    assign wb_valid = wr_en;
    assign wb_rd    = rd;
    assign wb_data  = wr_data;

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held for five rising edges
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== verif/tb_program.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int            tb_prog_len = 23;
localparam int            tb_lw_idx   = 19;
localparam rv_pkg::addr_t tb_lw_addr  = 32'h0000_009c;

// x1 = 5, x2 = -3, x3 = 0x12345678, then every kept op
localparam rv_pkg::word_t tb_prog [0:tb_prog_len-1] = '{
    32'h0050_0093,
    32'hffd0_0113,
    32'h1234_51b7,
    32'h6781_8193,
    32'h0020_8233,
    32'h4020_82b3,
    32'h0021_f333,
    32'h0030_e3b3,
    32'h0021_c433,
    32'h0010_94b3,
    32'h0011_5533,
    32'h4011_55b3,
    32'h0011_2633,
    32'h0f01_f713,
    32'hff00_e793,
    32'h7ff0_c813,
    32'h01c0_9893,
    32'h0041_5913,
    32'h4011_5993,
    // lw x20, -4(x9)
    32'hffc4_aa03,
    // addi x0, sw, then add x21 from x0
    32'h0070_8013,
    32'h0010_2023,
    32'h0000_0ab3
};

// {writes, rd, data} per program slot
localparam logic [37:0] tb_expect_wb [0:tb_prog_len-1] = '{
    {1'b1, 5'd1,  32'h0000_0005},
    {1'b1, 5'd2,  32'hffff_fffd},
    {1'b1, 5'd3,  32'h1234_5000},
    {1'b1, 5'd3,  32'h1234_5678},
    {1'b1, 5'd4,  32'h0000_0002},
    {1'b1, 5'd5,  32'h0000_0008},
    {1'b1, 5'd6,  32'h1234_5678},
    {1'b1, 5'd7,  32'h1234_567d},
    {1'b1, 5'd8,  32'hedcb_a985},
    {1'b1, 5'd9,  32'h0000_00a0},
    {1'b1, 5'd10, 32'h07ff_ffff},
    {1'b1, 5'd11, 32'hffff_ffff},
    {1'b1, 5'd12, 32'h0000_0001},
    {1'b1, 5'd14, 32'h0000_0070},
    {1'b1, 5'd15, 32'hffff_fff5},
    {1'b1, 5'd16, 32'h0000_07fa},
    {1'b1, 5'd17, 32'h5000_0000},
    {1'b1, 5'd18, 32'h0fff_ffff},
    {1'b1, 5'd19, 32'hffff_fffe},
    {1'b1, 5'd20, 32'ha539_5a5a},
    {1'b0, 5'd0,  32'h0000_0000},
    {1'b0, 5'd0,  32'h0000_0000},
    {1'b1, 5'd21, 32'h0000_0000}
};

// address halves swapped and xored with a constant
function automatic rv_pkg::word_t tb_dmem_word(input rv_pkg::addr_t addr);
    return {addr[15:0], addr[31:16]} ^ 32'ha5a5_5a5a;
endfunction

`endif

// ==== verif/rv_core_assert.sv ====
`default_nettype none

`include "rv_defs.svh"
`include "tb_program.svh"

module rv_core_assert (
    input logic             clk,
    input logic             rst_n,
    input rv_pkg::addr_t    imem_addr,
    input logic             imem_valid,
    input rv_pkg::addr_t    dmem_addr,
    input logic             wb_valid,
    input rv_pkg::reg_idx_t wb_rd,
    input rv_pkg::word_t    wb_data
);

    int            error_count = 0;
    rv_pkg::word_t slot;
    logic [37:0]   entry;

    assign slot  = imem_addr >> 2;
    assign entry = (slot < tb_prog_len) ? tb_expect_wb[slot[4:0]] : '0;

    reset_pc: assert property (@(posedge clk)
        (!rst_n || $rose(rst_n)) |-> (imem_addr == `RV_RESET_PC) && !wb_valid)
        else begin
            error_count++;
            $error("FAILED %0t: pc %h or wb_valid wrong around reset", $time, imem_addr);
        end

    // no writeback for stalls, x0 or unknown opcodes
    wb_gate: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid == (imem_valid && entry[37]))
        else begin
            error_count++;
            $error("FAILED %0t: wb_valid %b at pc %h", $time, wb_valid, imem_addr);
        end

    wb_match: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> (wb_rd == entry[36:32]) && (wb_data == entry[31:0]))
        else begin
            error_count++;
            $error("FAILED %0t: pc %h wrote x%0d = %h, expected x%0d = %h",
                $time, imem_addr, wb_rd, wb_data, entry[36:32], entry[31:0]);
        end

    load_check: assert property (@(posedge clk) disable iff (!rst_n)
        (imem_valid && slot == tb_lw_idx) |->
            (dmem_addr == tb_lw_addr) && (wb_data == tb_dmem_word(tb_lw_addr)))
        else begin
            error_count++;
            $error("FAILED %0t: lw address %h data %h", $time, dmem_addr, wb_data);
        end

    stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !imem_valid |=> imem_addr == $past(imem_addr))
        else begin
            error_count++;
            $error("FAILED %0t: pc moved to %h during a stall", $time, imem_addr);
        end

    pc_step: assert property (@(posedge clk) disable iff (!rst_n)
        imem_valid |=> imem_addr == $past(imem_addr) + `RV_PC_STEP)
        else begin
            error_count++;
            $error("FAILED %0t: pc %h after an accepted fetch", $time, imem_addr);
        end

endmodule

bind rv_core rv_core_assert u_checker (.*);

`default_nettype wire

// ==== verif/tb_rv_core.sv ====
`default_nettype none

`include "rv_defs.svh"
`include "tb_program.svh"

module tb_rv_core;

    localparam int            cycle_limit = 400;
    localparam rv_pkg::addr_t end_addr    = tb_prog_len * `RV_PC_STEP;

    logic             clk;
    logic             rst_n;
    rv_pkg::addr_t    imem_addr;
    rv_pkg::word_t    imem_data;
    logic             imem_valid;
    rv_pkg::addr_t    dmem_addr;
    rv_pkg::word_t    dmem_rdata;
    logic             wb_valid;
    rv_pkg::reg_idx_t wb_rd;
    rv_pkg::word_t    wb_data;
    int               seed;
    int               cycles;

    tb_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rv_core u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .imem_valid (imem_valid),
        .dmem_addr  (dmem_addr),
        .dmem_rdata (dmem_rdata),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    // rom reads as nop past the program end
    assign imem_data  = ((imem_addr >> 2) < tb_prog_len) ? tb_prog[imem_addr[6:2]]
                                                         : 32'h0000_0013;
    assign dmem_rdata = tb_dmem_word(dmem_addr);

    initial begin
        seed       = 32'hd70f_ae22;
        imem_valid = 1'b0;
    end

    // fetch valid about three cycles in four
    always @(posedge clk) begin
        if (!rst_n) begin
            imem_valid <= 1'b0;
        end else begin
            imem_valid <= ($random(seed) & 3) != 0;
        end
    end

    initial begin
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (imem_addr != end_addr && u_dut.u_checker.error_count == 0 &&
                   cycles < cycle_limit);
        if (u_dut.u_checker.error_count != 0) begin
            $display("Simulation failed");
            $fatal(1, "a check on the core outputs failed at time %0t", $time);
        end else if (imem_addr != end_addr) begin
            $display("Simulation failed");
            $fatal(1, "timeout, core stalled at pc %h after %0d cycles", imem_addr, cycles);
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+hw
+incdir+verif
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_core.sv
verif/tb_clk_gen.sv
verif/rv_core_assert.sv
verif/tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rv_core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_rv_core -f filelist.f \
    -o sim_rv_core > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim_rv_core +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation completed successfully" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
